/* common/lsu_cfg_pkg.sv */
package lsu_cfg_pkg;

   // default address width, the top level passes it down
   parameter int ADDR_W_DEFAULT = 32;

   parameter int BYTES_PER_WORD = 4;  // data word is 32 bits

   // byte offset widths inside a word and a double word
   parameter int WORD_OFS_W  = 2;
   parameter int DWORD_OFS_W = 3;

   // forwarding window spans two words
   parameter int LANES = 2 * BYTES_PER_WORD;

endpackage

/* common/lsu_types_pkg.sv */
package lsu_types_pkg;

   // encoded access size of a load or store
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } access_size_e;

   // one enable per byte lane, bits 3:0 low word and bits 7:4 high word
   typedef logic [lsu_cfg_pkg::LANES-1:0] lane_en_t;

   // word view of the window
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
   } window_words_t;

   // 8-byte lane window
   // bytes view for per-lane muxing, words view for shifts and word halves
   typedef union packed {
      logic [lsu_cfg_pkg::LANES-1:0][7:0] bytes;
      window_words_t                      words;
   } lane_window_u;

endpackage

/* hdl/access_decode.sv */
`timescale 1ns/1ns

module access_decode #(
   parameter int ADDR_W = lsu_cfg_pkg::ADDR_W_DEFAULT
) (
   input  lsu_types_pkg::access_size_e m_size,
   input  logic [ADDR_W-1:0]           m_addr,
   output lsu_types_pkg::lane_en_t     m_lane_en,
   output logic [ADDR_W-1:0]           m_end_addr,
   output logic                        m_dual
);

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   logic [BYTES_PER_WORD-1:0] word_en;   // enables before the lane shift
   logic [WORD_OFS_W-1:0]     last_ofs;  // size in bytes minus one

   always_comb begin
      case (m_size)
         size_half: begin
            word_en  = 4'b0011;
            last_ofs = 2'd1;
         end
         size_word: begin
            word_en  = 4'b1111;
            last_ofs = 2'd3;
         end
         default: begin  // byte, and the unused encoding
            word_en  = 4'b0001;
            last_ofs = 2'd0;
         end
      endcase
   end

   // place the enables at the byte offset, the overflow lands in the high word
   assign m_lane_en = lane_en_t'({{BYTES_PER_WORD{1'b0}}, word_en} << m_addr[WORD_OFS_W-1:0]);

   assign m_end_addr = m_addr + ADDR_W'(last_ofs);

   // access touches two words when the word index changes
   assign m_dual = m_addr[WORD_OFS_W] != m_end_addr[WORD_OFS_W];

endmodule

/* hdl/store_pipe_r.sv */
`timescale 1ns/1ns

module store_pipe_r #(
   parameter int ADDR_W = lsu_cfg_pkg::ADDR_W_DEFAULT
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    m_valid,
   input  logic                    m_load,
   input  logic                    flush_m,
   input  logic [ADDR_W-1:0]       m_addr,
   input  logic [ADDR_W-1:0]       m_end_addr,
   input  lsu_types_pkg::lane_en_t m_lane_en,
   input  logic                    m_dual,
   input  logic [31:0]             m_store_data,
   output logic                    r_valid,
   output logic                    r_store,
   output logic [ADDR_W-1:0]       r_addr,
   output logic [ADDR_W-1:0]       r_end_addr,
   output lsu_types_pkg::lane_en_t r_lane_en,
   output logic                    r_dual,
   output logic [31:0]             r_store_data,
   output logic                    no_word_merge,
   output logic                    no_dword_merge
);

   import lsu_cfg_pkg::*;

   logic dword_match;  // same double word in R and M
   logic word_match;   // same word in R and M
   logic merge_cand;   // R and M both present, R not dual

   // R stage control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_valid <= 1'b0;
         r_store <= 1'b0;
      end else begin
         r_valid <= m_valid & ~flush_m;  // a flushed access never reaches R
         r_store <= ~m_load;
      end
   end

   // R stage payload
   always_ff @(posedge clk) begin
      r_addr       <= m_addr;
      r_end_addr   <= m_end_addr;
      r_lane_en    <= m_lane_en;
      r_dual       <= m_dual;
      r_store_data <= m_store_data;
   end

   assign dword_match = r_addr[ADDR_W-1:DWORD_OFS_W] == m_addr[ADDR_W-1:DWORD_OFS_W];
   assign word_match  = dword_match & (r_addr[WORD_OFS_W] == m_addr[WORD_OFS_W]);

   assign merge_cand = r_valid & ~r_dual & m_valid;

   // an M load or a different address breaks the merge
   assign no_dword_merge = merge_cand & (m_load | ~dword_match);
   assign no_word_merge  = merge_cand & (m_load | ~word_match);

endmodule

/* fwd/store_fwd_hit.sv */
`timescale 1ns/1ns

module store_fwd_hit #(
   parameter int ADDR_W = lsu_cfg_pkg::ADDR_W_DEFAULT
) (
   input  logic                                   m_valid,
   input  logic [ADDR_W-1:0]                      m_addr,
   input  logic [ADDR_W-1:0]                      m_end_addr,
   input  lsu_types_pkg::lane_en_t                m_lane_en,
   input  logic                                   r_valid,
   input  logic                                   r_store,
   input  logic [ADDR_W-1:0]                      r_addr,
   input  logic [ADDR_W-1:0]                      r_end_addr,
   input  lsu_types_pkg::lane_en_t                r_lane_en,
   output logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_hit,
   output logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_hit,
   output logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_from_rhi,
   output logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_from_rhi,
   output logic                                   m_hit_any
);

   import lsu_cfg_pkg::*;

   logic                      fwd_ok;  // R holds a store and M is live
   logic                      mlo_rlo, mlo_rhi, mhi_rlo, mhi_rhi;
   logic [BYTES_PER_WORD-1:0] m_lo_en, m_hi_en;
   logic [BYTES_PER_WORD-1:0] r_lo_en, r_hi_en;

   assign fwd_ok = r_valid & r_store & m_valid;

   assign m_lo_en = m_lane_en[BYTES_PER_WORD-1:0];
   assign m_hi_en = m_lane_en[LANES-1:BYTES_PER_WORD];
   assign r_lo_en = r_lane_en[BYTES_PER_WORD-1:0];
   assign r_hi_en = r_lane_en[LANES-1:BYTES_PER_WORD];

   // word address pairings, start address gives the low word and end address the high word
   assign mlo_rlo = fwd_ok & (m_addr[ADDR_W-1:WORD_OFS_W] == r_addr[ADDR_W-1:WORD_OFS_W]);
   assign mlo_rhi = fwd_ok & (m_addr[ADDR_W-1:WORD_OFS_W] == r_end_addr[ADDR_W-1:WORD_OFS_W]);
   assign mhi_rlo = fwd_ok & (m_end_addr[ADDR_W-1:WORD_OFS_W] == r_addr[ADDR_W-1:WORD_OFS_W]);
   assign mhi_rhi = fwd_ok &
                    (m_end_addr[ADDR_W-1:WORD_OFS_W] == r_end_addr[ADDR_W-1:WORD_OFS_W]);

   always_comb begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         // the R halves never enable the same byte position, so at most one source hits
         lo_from_rhi[i] = mlo_rhi & r_hi_en[i] & m_lo_en[i];
         hi_from_rhi[i] = mhi_rhi & r_hi_en[i] & m_hi_en[i];
         lo_hit[i]      = (mlo_rlo & r_lo_en[i] & m_lo_en[i]) | lo_from_rhi[i];
         hi_hit[i]      = (mhi_rlo & r_lo_en[i] & m_hi_en[i]) | hi_from_rhi[i];
      end
   end

   assign m_hit_any = |{lo_hit, hi_hit};

endmodule

/* fwd/store_fwd_data.sv */
`timescale 1ns/1ns

module store_fwd_data (
   input  logic                                   m_valid,
   input  logic                                   m_load,
   input  logic                                   m_sideeffect,
   input  logic [lsu_cfg_pkg::WORD_OFS_W-1:0]     m_addr_ofs,
   input  lsu_types_pkg::lane_en_t                m_lane_en,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_hit,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_hit,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_from_rhi,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_from_rhi,
   input  logic                                   m_hit_any,
   input  logic [lsu_cfg_pkg::WORD_OFS_W-1:0]     r_addr_ofs,
   input  logic [31:0]                            r_store_data,
   output logic [31:0]                            load_data,
   output logic                                   load_full_hit
);

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   lane_window_u r_win;      // R store data placed at its byte offset
   lane_window_u fwd_win;    // forwarded bytes at M lane positions
   lane_window_u align_win;  // forwarded bytes moved down to the load address
   logic         full_lo, full_hi;

   assign r_win = {32'b0, r_store_data} << {r_addr_ofs, 3'b000};

   always_comb begin
      fwd_win = '0;  // bytes without a hit stay zero
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         if (lo_hit[i]) begin
            fwd_win.bytes[i] = lo_from_rhi[i] ? r_win.bytes[BYTES_PER_WORD+i] : r_win.bytes[i];
         end
         if (hi_hit[i]) begin
            fwd_win.bytes[BYTES_PER_WORD+i] = hi_from_rhi[i] ? r_win.bytes[BYTES_PER_WORD+i]
                                                             : r_win.bytes[i];
         end
      end
   end

   assign align_win = fwd_win >> {m_addr_ofs, 3'b000};
   assign load_data = align_win.words.lo;

   // every enabled lane of the load must be covered
   always_comb begin
      full_lo = 1'b1;
      full_hi = 1'b1;
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         full_lo &= lo_hit[i] | ~m_lane_en[i];
         full_hi &= hi_hit[i] | ~m_lane_en[BYTES_PER_WORD+i];
      end
   end

   assign load_full_hit = full_lo & full_hi & m_hit_any & m_valid & m_load & ~m_sideeffect;

endmodule

/* hdl/lsu_fwd_top.sv */
`timescale 1ns/1ns

module lsu_fwd_top #(
   parameter int ADDR_W = lsu_cfg_pkg::ADDR_W_DEFAULT
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        m_valid,
   input  logic                        m_load,
   input  lsu_types_pkg::access_size_e m_size,
   input  logic [ADDR_W-1:0]           m_addr,
   input  logic [31:0]                 m_store_data,
   input  logic                        m_sideeffect,
   input  logic                        flush_m,
   output logic                        m_dual,
   output logic [31:0]                 load_data,
   output logic                        load_full_hit,
   output logic                        no_word_merge,
   output logic                        no_dword_merge
);

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   // M stage decode results
   lane_en_t                  m_lane_en;
   logic [ADDR_W-1:0]         m_end_addr;

   // R stage copy of the previous access
   logic                      r_valid;
   logic                      r_store;
   logic [ADDR_W-1:0]         r_addr;
   logic [ADDR_W-1:0]         r_end_addr;
   lane_en_t                  r_lane_en;
   logic                      r_dual;
   logic [31:0]               r_store_data;

   // per-lane hits of M against R
   logic [BYTES_PER_WORD-1:0] lo_hit, hi_hit;
   logic [BYTES_PER_WORD-1:0] lo_from_rhi, hi_from_rhi;
   logic                      m_hit_any;

   access_decode #(.ADDR_W(ADDR_W)) decode_i (
      .m_size     (m_size),
      .m_addr     (m_addr),
      .m_lane_en  (m_lane_en),
      .m_end_addr (m_end_addr),
      .m_dual     (m_dual)
   );

   store_pipe_r #(.ADDR_W(ADDR_W)) pipe_r_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .m_valid        (m_valid),
      .m_load         (m_load),
      .flush_m        (flush_m),
      .m_addr         (m_addr),
      .m_end_addr     (m_end_addr),
      .m_lane_en      (m_lane_en),
      .m_dual         (m_dual),
      .m_store_data   (m_store_data),
      .r_valid        (r_valid),
      .r_store        (r_store),
      .r_addr         (r_addr),
      .r_end_addr     (r_end_addr),
      .r_lane_en      (r_lane_en),
      .r_dual         (r_dual),
      .r_store_data   (r_store_data),
      .no_word_merge  (no_word_merge),
      .no_dword_merge (no_dword_merge)
   );

   store_fwd_hit #(.ADDR_W(ADDR_W)) hit_i (
      .m_valid     (m_valid),
      .m_addr      (m_addr),
      .m_end_addr  (m_end_addr),
      .m_lane_en   (m_lane_en),
      .r_valid     (r_valid),
      .r_store     (r_store),
      .r_addr      (r_addr),
      .r_end_addr  (r_end_addr),
      .r_lane_en   (r_lane_en),
      .lo_hit      (lo_hit),
      .hi_hit      (hi_hit),
      .lo_from_rhi (lo_from_rhi),
      .hi_from_rhi (hi_from_rhi),
      .m_hit_any   (m_hit_any)
   );

   store_fwd_data data_i (
      .m_valid       (m_valid),
      .m_load        (m_load),
      .m_sideeffect  (m_sideeffect),
      .m_addr_ofs    (m_addr[WORD_OFS_W-1:0]),
      .m_lane_en     (m_lane_en),
      .lo_hit        (lo_hit),
      .hi_hit        (hi_hit),
      .lo_from_rhi   (lo_from_rhi),
      .hi_from_rhi   (hi_from_rhi),
      .m_hit_any     (m_hit_any),
      .r_addr_ofs    (r_addr[WORD_OFS_W-1:0]),
      .r_store_data  (r_store_data),
      .load_data     (load_data),
      .load_full_hit (load_full_hit)
   );

endmodule

/* tests/tb_lsu_fwd_checks.svh */
`ifndef TB_LSU_FWD_CHECKS_SVH
`define TB_LSU_FWD_CHECKS_SVH

// every output against the reference model, sampled on the rising edge

m_dual_check: assert property (@(posedge clk) disable iff (!rst_n)
   m_dual == exp_m_dual)
   else stop_on_error(mismatch_line("m_dual", 64'($sampled(exp_m_dual)),
                                    64'($sampled(m_dual))));

load_data_check: assert property (@(posedge clk) disable iff (!rst_n)
   load_data == exp_load_data)
   else stop_on_error(mismatch_line("load_data", 64'($sampled(exp_load_data)),
                                    64'($sampled(load_data))));

full_hit_check: assert property (@(posedge clk) disable iff (!rst_n)
   load_full_hit == exp_full_hit)
   else stop_on_error(mismatch_line("load_full_hit", 64'($sampled(exp_full_hit)),
                                    64'($sampled(load_full_hit))));

word_merge_check: assert property (@(posedge clk) disable iff (!rst_n)
   no_word_merge == exp_no_word)
   else stop_on_error(mismatch_line("no_word_merge", 64'($sampled(exp_no_word)),
                                    64'($sampled(no_word_merge))));

dword_merge_check: assert property (@(posedge clk) disable iff (!rst_n)
   no_dword_merge == exp_no_dword)
   else stop_on_error(mismatch_line("no_dword_merge", 64'($sampled(exp_no_dword)),
                                    64'($sampled(no_dword_merge))));

// empty R stage, all of it reads back as zero
// packed as {full_hit, no_word, no_dword, load_data}
empty_r_check: assert property (@(posedge clk) disable iff (!rst_n)
   !mr_valid |-> (load_data == 32'h0 && !load_full_hit && !no_word_merge && !no_dword_merge))
   else stop_on_error(mismatch_line("outputs with R empty", 64'h0,
                                    64'({$sampled(load_full_hit),
                                         $sampled(no_word_merge),
                                         $sampled(no_dword_merge),
                                         $sampled(load_data)})));

`endif

/* tests/tb_lsu_fwd.sv */
`timescale 1ns/1ns

module tb_lsu_fwd;

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int ADDR_W          = ADDR_W_DEFAULT;
   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 2;
   localparam int DIRECTED_CYCLES = 64;  // upper bound for the directed groups
   localparam int RANDOM_OPS      = 2000;
   localparam int TIMEOUT_NS      =
      (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_OPS + 20) * CLK_PERIOD;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              m_valid, m_load, m_sideeffect, flush_m;
   access_size_e      m_size;
   logic [ADDR_W-1:0] m_addr;
   logic [31:0]       m_store_data;
   logic              m_dual, load_full_hit, no_word_merge, no_dword_merge;
   logic [31:0]       load_data;

   // reference model keeps the previous M access as its R copy
   logic              mr_valid, mr_store, mr_dual;
   logic [ADDR_W-1:0] mr_addr;
   int                mr_bytes;
   logic [31:0]       mr_data;
   logic              exp_m_dual, exp_full_hit, exp_no_word, exp_no_dword, merge_cand;
   logic [31:0]       exp_load_data;

   string       test_name = "reset";
   logic [31:0] lfsr_state = 32'h55a0_9147;
   int          n_full = 0;
   int          n_dual = 0;
   int          n_word_only = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   lsu_fwd_top #(.ADDR_W(ADDR_W)) dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .m_valid        (m_valid),
      .m_load         (m_load),
      .m_size         (m_size),
      .m_addr         (m_addr),
      .m_store_data   (m_store_data),
      .m_sideeffect   (m_sideeffect),
      .flush_m        (flush_m),
      .m_dual         (m_dual),
      .load_data      (load_data),
      .load_full_hit  (load_full_hit),
      .no_word_merge  (no_word_merge),
      .no_dword_merge (no_dword_merge)
   );

   function automatic int size_bytes(input access_size_e size);
      case (size)
         size_half: return 2;
         size_word: return 4;
         default:   return 1;
      endcase
   endfunction

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'hb4bc_d35c : 32'h0);
      end
      return val;
   endfunction

   function automatic string mismatch_line(input string sig, input logic [63:0] exp_v,
                                           input logic [63:0] act_v);
      return $sformatf("MISMATCH test %s %s expected %0h actual %0h",
                       test_name, sig, exp_v, act_v);
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   // last byte falls into the next word
   assign exp_m_dual = (int'(m_addr[1:0]) + size_bytes(m_size)) > 4;

   // each load byte takes the R store byte at the same address or zero
   always_comb begin : fwd_model
      logic [ADDR_W-1:0] ofs;
      logic              fwd_ok, covered, all_hit;
      ofs           = '0;
      covered       = 1'b0;
      all_hit       = 1'b1;
      fwd_ok        = mr_valid & mr_store & m_valid;
      exp_load_data = '0;
      for (int k = 0; k < 4; k++) begin
         if (k < size_bytes(m_size)) begin
            ofs     = m_addr + ADDR_W'(k) - mr_addr;  // byte position inside the R store
            covered = 1'b0;
            for (int j = 0; j < 4; j++) begin
               if (fwd_ok && j < mr_bytes && ofs == ADDR_W'(j)) begin
                  exp_load_data[8*k +: 8] = mr_data[8*j +: 8];
                  covered                 = 1'b1;
               end
            end
            all_hit &= covered;
         end
      end
      exp_full_hit = all_hit & m_valid & m_load & ~m_sideeffect;
   end

   assign merge_cand   = mr_valid & ~mr_dual & m_valid;
   assign exp_no_dword = merge_cand & (m_load | (mr_addr[ADDR_W-1:3] != m_addr[ADDR_W-1:3]));
   assign exp_no_word  = merge_cand & (m_load | (mr_addr[ADDR_W-1:2] != m_addr[ADDR_W-1:2]));

   always @(posedge clk) begin
      if (!rst_n) begin
         mr_valid <= 1'b0;
      end else begin
         mr_valid <= m_valid & ~flush_m;
      end
      mr_store <= ~m_load;
      mr_addr  <= m_addr;
      mr_bytes <= size_bytes(m_size);
      mr_data  <= m_store_data;
      mr_dual  <= exp_m_dual;
   end

   // scenario counters so the end of the run can tell that the stimulus reached them
   always @(posedge clk) begin
      if (rst_n) begin
         if (exp_full_hit) n_full <= n_full + 1;
         if (m_valid && exp_m_dual) n_dual <= n_dual + 1;
         if (exp_no_word && !exp_no_dword) n_word_only <= n_word_only + 1;
      end
   end

   `include "tb_lsu_fwd_checks.svh"

   task automatic drive_access(input logic valid, input logic load, input access_size_e size,
                               input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic side, input logic flush);
      @(negedge clk);
      m_valid      = valid;
      m_load       = load;
      m_size       = size;
      m_addr       = addr;
      m_store_data = data;
      m_sideeffect = side;
      flush_m      = flush;
   endtask

   task automatic store_op(input access_size_e size, input logic [ADDR_W-1:0] addr,
                           input logic [31:0] data);
      drive_access(1'b1, 1'b0, size, addr, data, 1'b0, 1'b0);
   endtask

   task automatic load_op(input access_size_e size, input logic [ADDR_W-1:0] addr,
                          input logic side);
      drive_access(1'b1, 1'b1, size, addr, 32'hffff_ffff, side, 1'b0);
   endtask

   task automatic idle_cycle();
      drive_access(1'b0, 1'b0, size_byte, '0, 32'h0, 1'b0, 1'b0);
   endtask

   task automatic random_mix();
      logic [31:0]       sz, data;
      logic              valid, load, side, flush;
      access_size_e      size;
      logic [ADDR_W-1:0] addr;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         valid = lfsr_bits(3) != 32'h0;  // mostly busy
         load  = lfsr_bits(1) != 32'h0;
         sz    = lfsr_bits(2);
         size  = (sz == 32'h3) ? size_word : access_size_e'(sz[1:0]);
         addr  = ADDR_W'(32'h1000) + ADDR_W'(lfsr_bits(4));  // 16-byte window
         data  = lfsr_bits(32);
         side  = lfsr_bits(2) == 32'h3;
         flush = lfsr_bits(3) == 32'h0;
         drive_access(valid, load, size, addr, data, side, flush);
      end
   endtask

   initial begin
      #(TIMEOUT_NS);
      stop_on_error("watchdog expired before the test sequence finished");
   end

   initial begin
      rst_n        = 1'b0;
      m_valid      = 1'b0;
      m_load       = 1'b0;
      m_size       = size_byte;
      m_addr       = '0;
      m_store_data = 32'h0;
      m_sideeffect = 1'b0;
      flush_m      = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;

      load_op(size_word, 32'h1000, 1'b0);  // R stage still empty

      test_name = "decode";
      for (int s = 0; s < 3; s++) begin
         for (int ofs = 0; ofs < 4; ofs++) begin
            load_op(access_size_e'(s), 32'h3000 + ADDR_W'(ofs), 1'b0);
         end
      end

      test_name = "aligned";
      store_op(size_word, 32'h1000, 32'ha1b2_c3d4);
      load_op(size_byte, 32'h1001, 1'b0);
      store_op(size_word, 32'h1000, 32'ha1b2_c3d4);
      load_op(size_half, 32'h1002, 1'b0);
      store_op(size_word, 32'h1000, 32'ha1b2_c3d4);
      load_op(size_word, 32'h1000, 1'b0);
      store_op(size_word, 32'h1000, 32'ha1b2_c3d4);
      load_op(size_word, 32'h1000, 1'b1);  // side effect blocks the full hit

      test_name = "misaligned";
      store_op(size_word, 32'h1003, 32'h1122_3344);
      load_op(size_word, 32'h1004, 1'b0);
      store_op(size_word, 32'h1003, 32'h1122_3344);
      load_op(size_half, 32'h1005, 1'b0);
      store_op(size_word, 32'h1003, 32'h5566_7788);
      load_op(size_word, 32'h1003, 1'b0);
      store_op(size_byte, 32'h1002, 32'h0000_005a);
      load_op(size_word, 32'h1000, 1'b0);

      test_name = "flush_merge";
      drive_access(1'b1, 1'b0, size_word, 32'h2000, 32'hcafe_f00d, 1'b0, 1'b1);
      load_op(size_word, 32'h2000, 1'b0);
      store_op(size_word, 32'h2000, 32'h0102_0304);
      store_op(size_word, 32'h2000, 32'h0506_0708);  // same word
      store_op(size_word, 32'h2004, 32'h090a_0b0c);  // same double word
      store_op(size_word, 32'h200c, 32'h0d0e_0f10);  // next double word
      load_op(size_word, 32'h200c, 1'b0);
      store_op(size_word, 32'h2003, 32'h1112_1314);
      store_op(size_word, 32'h2003, 32'h1516_1718);  // dual R never merges
      idle_cycle();

      test_name = "random";
      random_mix();

      idle_cycle();
      idle_cycle();
      @(negedge clk);
      if (n_full == 0 || n_dual == 0 || n_word_only == 0) begin
         stop_on_error("stimulus never reached a full hit, a dual access or a word-only merge");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

/* src.f */
+incdir+tests
common/lsu_cfg_pkg.sv
common/lsu_types_pkg.sv
hdl/access_decode.sv
hdl/store_pipe_r.sv
fwd/store_fwd_hit.sv
fwd/store_fwd_data.sv
hdl/lsu_fwd_top.sv
tests/tb_lsu_fwd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it, a $fatal gives a failing exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f src.f \
   --top-module tb_lsu_fwd \
   -o sim_lsu_fwd

./obj_dir/sim_lsu_fwd
